//--- logic_pkg.sv
`default_nettype none

package logic_pkg;

	// alu operand and result width
	typedef logic [3:0] nibble_t;

	// alu function select, encoding follows the board switches
	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_not = 3'd2,
		op_and = 3'd3,
		op_or  = 3'd4,
		op_xor = 3'd5,
		op_lt  = 3'd6,
		op_eq  = 3'd7
	} alu_op_t;

	// decimal up count, 0 to 99
	typedef logic [7:0] count_t;

	// down count, wraps 0 to 7
	typedef logic [2:0] dcount_t;

	// one decimal digit
	typedef logic [3:0] digit_t;

	// bit 7 decimal point, bits 6..0 segments g..a, active low
	typedef logic [7:0] seg_t;

	localparam count_t count_max = 8'd99;

endpackage

`default_nettype wire

//--- video_pkg.sv
`default_nettype none

package video_pkg;

	// scan position in pixels or lines
	typedef logic [9:0] coord_t;

	// red 23..16, green 15..8, blue 7..0
	typedef logic [23:0] rgb_t;

	// colour tile index into vmem
	typedef logic [4:0] tile_t;

	// horizontal timing, 640x480 at 60 Hz
	localparam coord_t h_visible    = 10'd640;
	localparam coord_t h_sync_start = 10'd656;
	localparam coord_t h_sync_end   = 10'd752;
	localparam coord_t h_total      = 10'd800;

	// vertical timing in lines
	localparam coord_t v_visible    = 10'd480;
	localparam coord_t v_sync_start = 10'd490;
	localparam coord_t v_sync_end   = 10'd492;
	localparam coord_t v_total      = 10'd525;

endpackage

`default_nettype wire

//--- tick_timer.sv
`timescale 1ns/10ps
`default_nettype none

module tick_timer #(
	parameter int tick_div = 50_000_000
) (
	input  wire  clk,
	input  wire  arst_n,
	output logic tick
);

	localparam int cnt_w = (tick_div > 1) ? $clog2(tick_div) : 1;
	localparam logic [cnt_w-1:0] reload = cnt_w'(tick_div - 1);

	logic [cnt_w-1:0] cnt;

	// count down to zero, then reload and fire the tick for one cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt  <= reload;
			tick <= 1'b0;
		end else if (cnt == '0) begin
			cnt  <= reload;
			tick <= 1'b1;
		end else begin
			cnt  <= cnt - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- lab_counters.sv
`timescale 1ns/10ps
`default_nettype none

module lab_counters (
	input  wire                clk,
	input  wire                arst_n,
	input  wire                tick,
	input  wire                count_en,
	output logic_pkg::count_t  up_count,
	output logic_pkg::dcount_t down_count
);

	import logic_pkg::*;

	logic step;

	// counters only move on an enabled tick
	assign step = tick & count_en;

	// decimal up counter
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			up_count <= '0;
		end else if (step) begin
			if (up_count == count_max) begin
				up_count <= '0;
			end else begin
				up_count <= up_count + 1'b1;
			end
		end
	end

	// 3-bit down counter, wraps naturally from 0 to 7
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			down_count <= '0;
		end else if (step) begin
			down_count <= down_count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- seg_display.sv
`timescale 1ns/10ps
`default_nettype none

module seg_display (
	input  wire               clk,
	input  wire               arst_n,
	input  wire logic_pkg::count_t up_count,
	output logic_pkg::seg_t   seg0,
	output logic_pkg::seg_t   seg1,
	output logic_pkg::seg_t   seg2,
	output logic_pkg::seg_t   seg3,
	output logic_pkg::seg_t   seg4,
	output logic_pkg::seg_t   seg5,
	output logic_pkg::seg_t   seg6,
	output logic_pkg::seg_t   seg7
);

	import logic_pkg::*;

	localparam seg_t seg_blank = 8'hff;
	localparam seg_t seg_zero  = 8'hc0;

	digit_t units;
	digit_t tens;

	// active low, decimal point off
	function automatic seg_t encode_digit(input digit_t d);
		case (d)
			4'd0:    return 8'hc0;
			4'd1:    return 8'hf9;
			4'd2:    return 8'ha4;
			4'd3:    return 8'hb0;
			4'd4:    return 8'h99;
			4'd5:    return 8'h92;
			4'd6:    return 8'h82;
			4'd7:    return 8'hf8;
			4'd8:    return 8'h80;
			4'd9:    return 8'h90;
			default: return seg_blank;
		endcase
	endfunction

	// count never exceeds 99, so tens fits one digit
	assign units = digit_t'(up_count % count_t'(10));
	assign tens  = digit_t'(up_count / count_t'(10));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			seg0 <= seg_zero;
			seg1 <= seg_zero;
		end else begin
			seg0 <= encode_digit(units);
			seg1 <= encode_digit(tens);
		end
	end

	// upper six digits are unused on this board, held dark
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			{seg2, seg3, seg4, seg5, seg6, seg7} <= {6{seg_blank}};
		end else begin
			{seg2, seg3, seg4, seg5, seg6, seg7} <= {6{seg_blank}};
		end
	end

endmodule

`default_nettype wire

//--- alu_4bit.sv
`timescale 1ns/10ps
`default_nettype none

module alu_4bit (
	input  wire logic_pkg::alu_op_t alu_op,
	input  wire logic_pkg::nibble_t alu_a,
	input  wire logic_pkg::nibble_t alu_b,
	output logic_pkg::nibble_t      alu_res,
	output logic                    alu_zero,
	output logic                    alu_carry,
	output logic                    alu_overflow
);

	import logic_pkg::*;

	nibble_t    b_op;
	logic       c_in;
	logic [4:0] sum;

	// subtract is a + ~b + 1, so add and sub share one adder
	assign b_op = (alu_op == op_sub) ? ~alu_b : alu_b;
	assign c_in = (alu_op == op_sub);
	assign sum  = {1'b0, alu_a} + {1'b0, b_op} + {4'd0, c_in};

	always_comb begin
		alu_res      = '0;
		alu_carry    = 1'b0;
		alu_overflow = 1'b0;
		case (alu_op)
			op_add, op_sub: begin
				alu_res   = sum[3:0];
				alu_carry = sum[4];
				// signed overflow: same-sign operands, result sign differs
				alu_overflow = (alu_a[3] == b_op[3]) && (sum[3] != alu_a[3]);
			end
			op_not: alu_res = ~alu_a;
			op_and: alu_res = alu_a & alu_b;
			op_or:  alu_res = alu_a | alu_b;
			op_xor: alu_res = alu_a ^ alu_b;
			op_lt:  alu_res = ($signed(alu_a) < $signed(alu_b)) ? 4'd1 : 4'd0;
			op_eq:  alu_res = (alu_a == alu_b) ? 4'd1 : 4'd0;
			default: alu_res = '0;
		endcase
	end

	assign alu_zero = (alu_res == '0);

endmodule

`default_nettype wire

//--- vga_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module vga_ctrl (
	input  wire                  clk,
	input  wire                  arst_n,
	input  wire video_pkg::rgb_t pixel,
	output video_pkg::coord_t    h_addr,
	output video_pkg::coord_t    v_addr,
	output logic                 hsync,
	output logic                 vsync,
	output logic                 blank_n,
	output logic [7:0]           vga_r,
	output logic [7:0]           vga_g,
	output logic [7:0]           vga_b
);

	import video_pkg::*;

	logic h_end;
	logic v_end;

	assign h_end = (h_addr == h_total - 1'b1);
	assign v_end = (v_addr == v_total - 1'b1);

	// column counter, one pixel per clk
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			h_addr <= '0;
		end else if (h_end) begin
			h_addr <= '0;
		end else begin
			h_addr <= h_addr + 1'b1;
		end
	end

	// line counter advances at the end of each line
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			v_addr <= '0;
		end else if (h_end) begin
			if (v_end) begin
				v_addr <= '0;
			end else begin
				v_addr <= v_addr + 1'b1;
			end
		end
	end

	// both syncs are negative pulses
	assign hsync = !((h_addr >= h_sync_start) && (h_addr < h_sync_end));
	assign vsync = !((v_addr >= v_sync_start) && (v_addr < v_sync_end));

	assign blank_n = (h_addr < h_visible) && (v_addr < v_visible);

	// colour only inside the visible area
	assign vga_r = blank_n ? pixel[23:16] : 8'd0;
	assign vga_g = blank_n ? pixel[15:8]  : 8'd0;
	assign vga_b = blank_n ? pixel[7:0]   : 8'd0;

endmodule

`default_nettype wire

//--- vmem.sv
`timescale 1ns/10ps
`default_nettype none

module vmem (
	input  wire video_pkg::coord_t h_addr,
	input  wire video_pkg::coord_t v_addr,
	output video_pkg::rgb_t        pixel
);

	import video_pkg::*;

	localparam int tile_count = 32;

	rgb_t  mem [0:tile_count-1];
	tile_t tile;

	initial begin
		$readmemh("vmem.hex", mem);
	end

	// 128x128 tiles, 5 across and 4 down in the visible area
	assign tile  = {v_addr[8:7], h_addr[9:7]};
	assign pixel = mem[tile];

endmodule

`default_nettype wire

//--- lab_top.sv
`timescale 1ns/10ps
`default_nettype none

module lab_top #(
	parameter int tick_div = 50_000_000
) (
	input  wire                     clk,
	input  wire                     arst_n,
	input  wire                     count_en,
	input  wire logic_pkg::alu_op_t alu_op,
	input  wire logic_pkg::nibble_t alu_a,
	input  wire logic_pkg::nibble_t alu_b,
	output logic_pkg::count_t       inc_count,
	output logic_pkg::dcount_t      dec_count,
	output logic_pkg::seg_t         seg0,
	output logic_pkg::seg_t         seg1,
	output logic_pkg::seg_t         seg2,
	output logic_pkg::seg_t         seg3,
	output logic_pkg::seg_t         seg4,
	output logic_pkg::seg_t         seg5,
	output logic_pkg::seg_t         seg6,
	output logic_pkg::seg_t         seg7,
	output logic_pkg::nibble_t      alu_res,
	output logic                    alu_zero,
	output logic                    alu_carry,
	output logic                    alu_overflow,
	output logic                    vga_clk,
	output logic                    vga_hsync,
	output logic                    vga_vsync,
	output logic                    vga_blank_n,
	output logic [7:0]              vga_r,
	output logic [7:0]              vga_g,
	output logic [7:0]              vga_b
);

	import video_pkg::*;

	logic   tick;
	coord_t h_addr;
	coord_t v_addr;
	rgb_t   pixel;

	// pixel clock is the system clock
	assign vga_clk = clk;

	tick_timer #(
		.tick_div(tick_div)
	) i_tick_timer (
		.clk   (clk),
		.arst_n(arst_n),
		.tick  (tick)
	);

	lab_counters i_lab_counters (
		.clk       (clk),
		.arst_n    (arst_n),
		.tick      (tick),
		.count_en  (count_en),
		.up_count  (inc_count),
		.down_count(dec_count)
	);

	seg_display i_seg_display (
		.clk     (clk),
		.arst_n  (arst_n),
		.up_count(inc_count),
		.seg0    (seg0),
		.seg1    (seg1),
		.seg2    (seg2),
		.seg3    (seg3),
		.seg4    (seg4),
		.seg5    (seg5),
		.seg6    (seg6),
		.seg7    (seg7)
	);

	alu_4bit i_alu_4bit (
		.alu_op      (alu_op),
		.alu_a       (alu_a),
		.alu_b       (alu_b),
		.alu_res     (alu_res),
		.alu_zero    (alu_zero),
		.alu_carry   (alu_carry),
		.alu_overflow(alu_overflow)
	);

	vga_ctrl i_vga_ctrl (
		.clk    (clk),
		.arst_n (arst_n),
		.pixel  (pixel),
		.h_addr (h_addr),
		.v_addr (v_addr),
		.hsync  (vga_hsync),
		.vsync  (vga_vsync),
		.blank_n(vga_blank_n),
		.vga_r  (vga_r),
		.vga_g  (vga_g),
		.vga_b  (vga_b)
	);

	vmem i_vmem (
		.h_addr(h_addr),
		.v_addr(v_addr),
		.pixel (pixel)
	);

endmodule

`default_nettype wire

//--- lab_top_properties.sv
`timescale 1ns/10ps
`default_nettype none

module lab_top_properties #(
	parameter bit sync_checks = 1'b1,
	parameter bit dp_checks   = 1'b1
) (
	input wire       clk,
	input wire       arst_n,
	input wire       hsync,
	input wire       vsync,
	input wire       blank_n,
	input wire [7:0] dp
);

	if (sync_checks) begin : g_sync
		// no picture while the horizontal sync pulse is active
		assert property (@(posedge clk) disable iff (!arst_n) !hsync |-> !blank_n)
			else $error("blank_n high during hsync pulse");

		// syncs idle high while in reset
		assert property (@(posedge clk) !arst_n |-> (hsync && vsync))
			else $error("sync output low during reset");
	end

	if (dp_checks) begin : g_dp
		// decimal points stay dark
		assert property (@(posedge clk) disable iff (!arst_n) &dp)
			else $error("decimal point lit on a segment output");
	end

endmodule

bind vga_ctrl lab_top_properties #(
	.dp_checks(1'b0)
) i_vga_props (
	.clk    (clk),
	.arst_n (arst_n),
	.hsync  (hsync),
	.vsync  (vsync),
	.blank_n(blank_n),
	.dp     (8'hff)
);

// seg_display has no sync outputs, so only the decimal point check runs there
bind seg_display lab_top_properties #(
	.sync_checks(1'b0)
) i_seg_props (
	.clk    (clk),
	.arst_n (arst_n),
	.hsync  (1'b1),
	.vsync  (1'b1),
	.blank_n(1'b0),
	.dp     ({seg0[7], seg1[7], seg2[7], seg3[7], seg4[7], seg5[7], seg6[7], seg7[7]})
);

`default_nettype wire

//--- tb_lab_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_lab_top;

	import logic_pkg::*;
	import video_pkg::*;

	localparam int div = 4;

	logic       clk;
	logic       arst_n;
	logic       count_en;
	alu_op_t    alu_op;
	nibble_t    alu_a;
	nibble_t    alu_b;
	count_t     inc_count;
	dcount_t    dec_count;
	seg_t       seg0;
	seg_t       seg1;
	seg_t       seg2;
	seg_t       seg3;
	seg_t       seg4;
	seg_t       seg5;
	seg_t       seg6;
	seg_t       seg7;
	nibble_t    alu_res;
	logic       alu_zero;
	logic       alu_carry;
	logic       alu_overflow;
	logic       vga_clk;
	logic       vga_hsync;
	logic       vga_vsync;
	logic       vga_blank_n;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;

	rgb_t    tb_vmem [0:31];
	integer  seed;
	integer  errors;
	logic    checks_on;
	integer  edges;
	count_t  ref_inc;
	dcount_t ref_dec;
	seg_t    ref_seg0;
	seg_t    ref_seg1;

	lab_top #(
		.tick_div(div)
	) i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// standard active-low digit table, decimal point off
	function automatic seg_t seg_ref(input digit_t d);
		case (d)
			4'd0:    return 8'hc0;
			4'd1:    return 8'hf9;
			4'd2:    return 8'ha4;
			4'd3:    return 8'hb0;
			4'd4:    return 8'h99;
			4'd5:    return 8'h92;
			4'd6:    return 8'h82;
			4'd7:    return 8'hf8;
			4'd8:    return 8'h80;
			4'd9:    return 8'h90;
			default: return 8'hff;
		endcase
	endfunction

	// returns {result, zero, carry, overflow}
	function automatic logic [6:0] alu_ref(input alu_op_t op, input nibble_t a,
			input nibble_t b);
		integer  sa;
		integer  sb;
		integer  sr;
		nibble_t r;
		logic    c;
		logic    v;
		sa = $signed(a);
		sb = $signed(b);
		sr = 0;
		c = 1'b0;
		r = '0;
		case (op)
			op_add: begin
				{c, r} = a + b;
				sr = sa + sb;
			end
			op_sub: begin
				{c, r} = {1'b0, a} + {1'b0, ~b} + 5'd1;
				sr = sa - sb;
			end
			op_not:  r = ~a;
			op_and:  r = a & b;
			op_or:   r = a | b;
			op_xor:  r = a ^ b;
			op_lt:   r = (sa < sb) ? 4'd1 : 4'd0;
			default: r = (a == b) ? 4'd1 : 4'd0;
		endcase
		// signed result outside -8..7 means overflow
		v = (sr > 7) || (sr < -8);
		return {r, r == 4'd0, c, v};
	endfunction

	// tiles are 128 pixels square, eight index slots per tile row
	function automatic rgb_t pixel_ref(input coord_t col, input coord_t line);
		return tb_vmem[(line / 128) * 8 + col / 128];
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		errors++;
		$display("ERROR %s expected %0h actual %0h", name, exp, act);
	endtask

	task automatic check_nibble(input string name, input nibble_t exp, input nibble_t act);
		if (act !== exp) report_mismatch(name, exp, act);
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) report_mismatch(name, exp, act);
	endtask

	task automatic check_count(input string name, input count_t exp, input count_t act);
		if (act !== exp) report_mismatch(name, exp, act);
	endtask

	task automatic check_seg(input string name, input seg_t exp, input seg_t act);
		if (act !== exp) report_mismatch(name, exp, act);
	endtask

	task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
		if (act !== exp) report_mismatch(name, exp, act);
	endtask

	task automatic apply_reset();
		@(negedge clk);
		arst_n = 1'b0;
		repeat (2) @(negedge clk);
		arst_n = 1'b1;
	endtask

	task automatic wait_for_count(input count_t target, input integer limit);
		integer k;
		k = 0;
		while (inc_count !== target && k < limit) begin
			k++;
			@(negedge clk);
		end
		if (inc_count !== target) begin
			$display("timeout while waiting for inc_count to reach %0d", target);
			$display("test failed");
			$finish;
		end
	endtask

	// counter and display model, the tick first fires div cycles after release
	always @(posedge clk) begin
		if (!arst_n) begin
			edges = 0;
			ref_inc = '0;
			ref_dec = '0;
			ref_seg0 = seg_ref(4'd0);
			ref_seg1 = seg_ref(4'd0);
		end else begin
			edges++;
			ref_seg0 = seg_ref(digit_t'(ref_inc % 10));
			ref_seg1 = seg_ref(digit_t'(ref_inc / 10));
			if (count_en && edges > div && edges % div == 1) begin
				ref_inc = (ref_inc == 8'd99) ? 8'd0 : ref_inc + 8'd1;
				ref_dec = ref_dec - 3'd1;
			end
		end
	end

	always @(negedge clk) begin
		if (checks_on) begin
			check_count("count inc_count", ref_inc, inc_count);
			check_count("count dec_count", count_t'(ref_dec), count_t'(dec_count));
			check_seg("display seg0", ref_seg0, seg0);
			check_seg("display seg1", ref_seg1, seg1);
		end
	end

	initial begin
		integer     i;
		integer     n;
		integer     last_fall;
		integer     low_cnt;
		integer     periods;
		logic [31:0] rnd;
		logic [6:0] exp_alu;
		logic [7:0] seen;
		count_t     held;
		coord_t     col;
		coord_t     line;
		logic       exp_blank_n;
		logic       prev_hsync;
		rgb_t       exp_rgb;
		seed = 32'h88c6;
		errors = 0;
		checks_on = 1'b0;
		arst_n = 1'b0;
		count_en = 1'b0;
		alu_op = op_add;
		alu_a = '0;
		alu_b = '0;
		seen = '0;
		$readmemh("vmem.hex", tb_vmem);
		apply_reset();
		checks_on = 1'b1;

		// state straight after reset
		check_count("reset inc_count", 8'd0, inc_count);
		check_count("reset dec_count", 8'd0, count_t'(dec_count));
		check_seg("reset seg0", 8'hc0, seg0);
		check_seg("reset seg1", 8'hc0, seg1);
		check_seg("reset seg2", 8'hff, seg2);
		check_seg("reset seg3", 8'hff, seg3);
		check_seg("reset seg4", 8'hff, seg4);
		check_seg("reset seg5", 8'hff, seg5);
		check_seg("reset seg6", 8'hff, seg6);
		check_seg("reset seg7", 8'hff, seg7);
		check_bit("reset hsync", 1'b1, vga_hsync);
		check_bit("reset vsync", 1'b1, vga_vsync);

		// count through a full wrap of the decimal counter
		count_en = 1'b1;
		wait_for_count(8'd99, 120 * div);
		wait_for_count(8'd0, 3 * div);
		wait_for_count(8'd3, 4 * div);

		// disabled counters hold for several tick periods
		@(negedge clk);
		count_en = 1'b0;
		held = inc_count;
		repeat (5 * div) @(negedge clk);
		check_count("hold inc_count", held, inc_count);

		// pixel clock follows clk in both phases
		#25;
		check_bit("vga clk low", 1'b0, vga_clk);
		#50;
		check_bit("vga clk high", 1'b1, vga_clk);

		for (i = 0; i < 200; i++) begin
			@(negedge clk);
			rnd = $random(seed);
			alu_op = alu_op_t'(rnd[2:0]);
			alu_a = rnd[6:3];
			alu_b = rnd[10:7];
			@(posedge clk);
			exp_alu = alu_ref(alu_op, alu_a, alu_b);
			seen[alu_op] = 1'b1;
			check_nibble("alu res", exp_alu[6:3], alu_res);
			check_bit("alu zero", exp_alu[2], alu_zero);
			check_bit("alu carry", exp_alu[1], alu_carry);
			check_bit("alu overflow", exp_alu[0], alu_overflow);
		end
		if (seen !== 8'hff) begin
			errors++;
			$display("not every alu operation was exercised");
		end

		// restart the scan so the tracked coordinates begin at 0,0
		checks_on = 1'b0;
		apply_reset();
		checks_on = 1'b1;
		col = '0;
		line = '0;
		last_fall = -1;
		low_cnt = 0;
		periods = 0;
		prev_hsync = 1'b1;
		for (n = 0; n < 3 * h_total; n++) begin
			exp_blank_n = (col < 10'd640) && (line < 10'd480);
			exp_rgb = exp_blank_n ? pixel_ref(col, line) : 24'd0;
			check_bit("vga blank_n", exp_blank_n, vga_blank_n);
			check_bit("vga vsync", 1'b1, vga_vsync);
			check_rgb("vga rgb", exp_rgb, {vga_r, vga_g, vga_b});
			if (prev_hsync && !vga_hsync) begin
				if (last_fall >= 0) begin
					periods++;
					if (n - last_fall != 800) report_mismatch("vga hsync period", 800, n - last_fall);
				end
				last_fall = n;
			end
			if (!prev_hsync && vga_hsync) begin
				if (low_cnt != 96) report_mismatch("vga hsync width", 96, low_cnt);
				low_cnt = 0;
			end
			if (!vga_hsync) low_cnt++;
			prev_hsync = vga_hsync;
			@(negedge clk);
			col = (col == 10'd799) ? 10'd0 : col + 10'd1;
			if (col == 10'd0) line = line + 10'd1;
		end
		if (periods < 2) begin
			errors++;
			$display("hsync did not pulse once per scan line");
		end

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vmem.hex
// one 24-bit rgb colour per line (rrggbb), line n is tile n
// tile index is {v_addr[8:7], h_addr[9:7]}
ff0000
00ff00
0000ff
ffff00
00ffff
ff00ff
808080
ffffff
c04000
40c000
0040c0
c0c040
40c0c0
c040c0
202020
e0e0e0
800000
008000
000080
808000
008080
800080
404040
a0a0a0
ff8000
80ff00
0080ff
ff0080
00ff80
8000ff
123456
fedcba

//--- lab_top.f
logic_pkg.sv
video_pkg.sv
tick_timer.sv
lab_counters.sv
seg_display.sv
alu_4bit.sv
vga_ctrl.sv
vmem.sv
lab_top.sv
lab_top_properties.sv
tb_lab_top.sv

//--- Bender.yml
package:
  name: lab_top

sources:
  - logic_pkg.sv
  - video_pkg.sv
  - tick_timer.sv
  - lab_counters.sv
  - seg_display.sv
  - alu_4bit.sv
  - vga_ctrl.sv
  - vmem.sv
  - lab_top.sv
  - target: test
    files:
      - lab_top_properties.sv
      - tb_lab_top.sv
